/* sim.f */
hdl/mipsPkg.sv
hdl/decoder.sv
hdl/regFile.sv
hdl/alu.sv
hdl/hazardUnit.sv
hdl/stageReg.sv
hdl/datapath.sv
dv/datapath_chk.sv
dv/datapathTb.sv

/* dv/datapathTb.sv */
module datapathTb;
    timeunit 1ns;
    timeprecision 100ps;
    import mipsPkg::*;

    localparam int RST_CYCLES = 10;

    typedef enum logic [1:0] {
        KIND_NONE  = 2'd0,
        KIND_REG   = 2'd1,
        KIND_STORE = 2'd2
    } kindT;

    logic    clk = 1'b0;
    logic    rstN;
    wordT    instr;
    wordT    memRdata;
    wordT    pc;
    wordT    memAddr;
    wordT    memWdata;
    logic    memWe;
    logic    memRe;
    logic    wbEn;
    regAddrT wbReg;
    wordT    wbData;
    wordT    wbPc;

    // program table, row i sits at pc 4*i
    string tName[$];
    wordT  tInstr[$];
    kindT  tKind[$];
    wordT  tWhere[$];  // dest register or store address
    wordT  tValue[$];

    wordT imem [256];
    wordT dmem [64];
    int   nextRow = 0;
    int   cycles = 0;

    datapath #(.resetPc(32'h0)) i_dut (
        .clk_i      (clk),
        .rstN_i     (rstN),
        .instr_i    (instr),
        .memRdata_i (memRdata),
        .pc_o       (pc),
        .memAddr_o  (memAddr),
        .memWdata_o (memWdata),
        .memWe_o    (memWe),
        .memRe_o    (memRe),
        .wbEn_o     (wbEn),
        .wbReg_o    (wbReg),
        .wbData_o   (wbData),
        .wbPc_o     (wbPc)
    );

    bind datapath datapathChk i_chk (
        .clk_i   (clk_i),
        .rstN_i  (rstN_i),
        .pc_i    (pc_o),
        .memWe_i (memWe_o),
        .memRe_i (memRe_o),
        .wbEn_i  (wbEn_o)
    );

    always #2 clk = ~clk;

    function automatic wordT rType(logic [5:0] fn, int rs, int rt, int rd);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic wordT iType(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic addRow(string name, wordT ins, kindT kind, wordT where, wordT value);
        tName.push_back(name);
        tInstr.push_back(ins);
        tKind.push_back(kind);
        tWhere.push_back(where);
        tValue.push_back(value);
    endtask

    task automatic checkEq(string what, wordT expected, wordT actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", what, expected, actual);
            $display("Regression failed");
            $fatal(1, "value mismatch in %s", what);
        end
    endtask

    task automatic rejectExtra(string ev);
        if (nextRow >= tName.size()) begin
            $display("%s seen after every table row was matched", ev);
            $display("Regression failed");
            $fatal(1, "unexpected %s", ev);
        end
    endtask

    task automatic stopOnAssertion();
        if (i_dut.i_chk.failCount != 0) begin
            $display("bound checker saw %0d assertion failures", i_dut.i_chk.failCount);
            $display("Regression failed");
            $fatal(1, "assertion failure in the bound checker");
        end
    endtask

    function automatic void skipQuiet();
        while (nextRow < tName.size() && tKind[nextRow] == KIND_NONE) begin
            nextRow++;
        end
    endfunction

    task automatic buildProgram();
        addRow("addiu pos", iType(OP_ADDIU, 0, 1, 16'h0005), KIND_REG, 1, 32'h00000005);
        addRow("addiu neg", iType(OP_ADDIU, 0, 2, 16'hFFFD), KIND_REG, 2, 32'hFFFFFFFD);
        addRow("ori zext", iType(OP_ORI, 0, 3, 16'h8001), KIND_REG, 3, 32'h00008001);
        addRow("lui", iType(OP_LUI, 0, 4, 16'h1234), KIND_REG, 4, 32'h12340000);
        addRow("andi zext", iType(OP_ANDI, 2, 5, 16'hF0F0), KIND_REG, 5, 32'h0000F0F0);
        addRow("addu wrap", rType(FN_ADDU, 2, 1, 6), KIND_REG, 6, 32'h00000002);
        addRow("subu", rType(FN_SUBU, 1, 4, 7), KIND_REG, 7, 32'hEDCC0005);
        addRow("and", rType(FN_AND, 2, 3, 8), KIND_REG, 8, 32'h00008001);
        addRow("or", rType(FN_OR, 1, 4, 9), KIND_REG, 9, 32'h12340005);
        addRow("xor", rType(FN_XOR, 2, 1, 10), KIND_REG, 10, 32'hFFFFFFF8);
        addRow("slt signed", rType(FN_SLT, 2, 1, 11), KIND_REG, 11, 32'h00000001);
        addRow("lui upper", iType(OP_LUI, 0, 12, 16'h7FFF), KIND_REG, 12, 32'h7FFF0000);
        addRow("ori dist1", iType(OP_ORI, 12, 12, 16'hFFFF), KIND_REG, 12, 32'h7FFFFFFF);
        addRow("addu dist1", rType(FN_ADDU, 12, 1, 13), KIND_REG, 13, 32'h80000004);
        addRow("subu dist1 dist2", rType(FN_SUBU, 13, 12, 14), KIND_REG, 14, 32'h00000005);
        addRow("lw", iType(OP_LW, 0, 15, 16'h0040), KIND_REG, 15, 32'hCAFE0000);
        addRow("addu load use", rType(FN_ADDU, 15, 1, 16), KIND_REG, 16, 32'hCAFE0005);
        addRow("addiu after stall", iType(OP_ADDIU, 16, 17, 16'h0010), KIND_REG, 17,
               32'hCAFE0015);
        // base r1 = 5, so 5 + 0x7b lands on 0x80
        addRow("sw fwd data", iType(OP_SW, 1, 17, 16'h007B), KIND_STORE, 32'h80, 32'hCAFE0015);
        addRow("lw stored", iType(OP_LW, 0, 18, 16'h0080), KIND_REG, 18, 32'hCAFE0015);
        addRow("addiu to r0", iType(OP_ADDIU, 1, 0, 16'h0007), KIND_NONE, 0, 0);
        addRow("addu from r0", rType(FN_ADDU, 0, 1, 19), KIND_REG, 19, 32'h00000005);
        addRow("addi unsupported", iType(6'h08, 1, 2, 16'h0001), KIND_NONE, 0, 0);
        addRow("or after unsupported", rType(FN_OR, 2, 0, 20), KIND_REG, 20, 32'hFFFFFFFD);
    endtask

    assign instr = imem[pc[9:2]];  // no-ops past the table

    always @(posedge clk) begin
        if (memWe) begin
            dmem[memAddr[7:2]] <= memWdata;
        end
        if (memRe) begin
            memRdata <= dmem[memAddr[7:2]];  // back in writeback
        end
    end

    initial begin
        rstN = 1'b0;
        memRdata = '0;
        buildProgram();
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < tInstr.size(); i++) begin
            imem[i] = tInstr[i];
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = '0;
        end
        dmem[16] = 32'hCAFE0000;  // byte address 0x40
        repeat (RST_CYCLES) @(posedge clk);
        rstN <= 1'b1;
    end

    // outputs settle after the rising edge
    always @(negedge clk) begin
        stopOnAssertion();
        if (rstN) begin
            skipQuiet();
            if (wbEn) begin  // older than the store
                rejectExtra("writeback");
                checkEq({tName[nextRow], " kind"}, 32'(tKind[nextRow]), 32'(KIND_REG));
                checkEq({tName[nextRow], " reg"}, tWhere[nextRow], 32'(wbReg));
                checkEq({tName[nextRow], " data"}, tValue[nextRow], wbData);
                checkEq({tName[nextRow], " pc"}, 32'(nextRow * 4), wbPc);
                nextRow++;
                skipQuiet();
            end
            if (memWe) begin
                rejectExtra("store");
                checkEq({tName[nextRow], " kind"}, 32'(tKind[nextRow]), 32'(KIND_STORE));
                checkEq({tName[nextRow], " addr"}, tWhere[nextRow], memAddr);
                checkEq({tName[nextRow], " data"}, tValue[nextRow], memWdata);
                nextRow++;
                skipQuiet();
            end
            if (nextRow >= tName.size()) begin
                $display("Regression passed");
                $finish;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= RST_CYCLES + 5 + 2 * tName.size() + 20) begin
            $display("timeout after %0d cycles with %0d of %0d rows matched",
                     cycles, nextRow, tName.size());
            $display("Regression failed");
            $fatal(1, "run did not finish in time");
        end
    end

endmodule

/* dv/datapath_chk.sv */
module datapathChk (
    input logic          clk_i,
    input logic          rstN_i,
    input mipsPkg::wordT pc_i,
    input logic          memWe_i,
    input logic          memRe_i,
    input logic          wbEn_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned failCount = 0;

    // registers clear on the edge that samples reset
    strobesLowInReset: assert property (
        @(posedge clk_i) !rstN_i |=> (!memWe_i && !wbEn_i)
    ) else begin
        failCount++;
        $error("write strobe active during reset");
    end

    pcHoldsOrSteps: assert property (
        @(posedge clk_i) (rstN_i && $past(rstN_i))
            |-> (pc_i == $past(pc_i) || pc_i == $past(pc_i) + 32'd4)
    ) else begin
        failCount++;
        $error("pc moved by something other than 0 or 4");
    end

    noReadWithWrite: assert property (
        @(posedge clk_i) rstN_i |-> !(memWe_i && memRe_i)
    ) else begin
        failCount++;
        $error("memory read and write in the same cycle");
    end

endmodule

/* hdl/datapath.sv */
module datapath #(
    parameter mipsPkg::wordT resetPc = '0
) (
    input  logic             clk_i,
    input  logic             rstN_i,
    input  mipsPkg::wordT    instr_i,
    input  mipsPkg::wordT    memRdata_i,
    output mipsPkg::wordT    pc_o,
    output mipsPkg::wordT    memAddr_o,
    output mipsPkg::wordT    memWdata_o,
    output logic             memWe_o,
    output logic             memRe_o,
    output logic             wbEn_o,
    output mipsPkg::regAddrT wbReg_o,
    output mipsPkg::wordT    wbData_o,
    output mipsPkg::wordT    wbPc_o
);
    import mipsPkg::*;

    wordT     pcQ;
    logic     stall;

    fetchDecT fdD;
    fetchDecT fdQ;
    decExT    deD;
    decExT    deQ;
    exMemT    emD;
    exMemT    emQ;
    memWbT    mwD;
    memWbT    mwQ;

    wordT     instrD;
    regAddrT  rsD;
    regAddrT  rtD;
    regAddrT  rdD;
    ctrlT     ctrlD;
    wordT     immD;
    wordT     rd1D;
    wordT     rd2D;

    fwdSelT   fwdA;
    fwdSelT   fwdB;
    wordT     srcAE;
    wordT     fwdBE;
    wordT     srcBE;
    wordT     aluOutE;

    wordT     wbData;
    logic     wbWe;

    function automatic wordT pickFwd(fwdSelT sel, wordT rf, wordT fromMem, wordT fromWb);
        case (sel)
            FWD_MEM: return fromMem;
            FWD_WB:  return fromWb;
            default: return rf;
        endcase
    endfunction

    // fetch
    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            pcQ <= resetPc;
        end else if (!stall) begin
            pcQ <= pcQ + 32'd4;
        end
    end

    assign pc_o = pcQ;

    always_comb begin
        fdD.pc    = pcQ;
        fdD.instr = instr_i;
    end

    stageReg #(.payloadT(fetchDecT)) i_fdReg (
        .clk_i   (clk_i),
        .rstN_i  (rstN_i),
        .en_i    (!stall),
        .flush_i (1'b0),
        .d_i     (fdD),
        .q_o     (fdQ)
    );

    // decode
    assign instrD = fdQ.instr;
    assign rsD    = instrD[25:21];
    assign rtD    = instrD[20:16];
    assign rdD    = instrD[15:11];

    decoder i_decoder (
        .instr_i (instrD),
        .ctrl_o  (ctrlD),
        .imm_o   (immD)
    );

    regFile i_regFile (
        .clk_i    (clk_i),
        .rstN_i   (rstN_i),
        .raddrA_i (rsD),
        .raddrB_i (rtD),
        .we_i     (wbWe),
        .waddr_i  (mwQ.dest),
        .wdata_i  (wbData),
        .rdataA_o (rd1D),
        .rdataB_o (rd2D)
    );

    always_comb begin
        deD.pc   = fdQ.pc;
        deD.ctrl = ctrlD;
        deD.rs   = rsD;
        deD.rt   = rtD;
        deD.dest = ctrlD.regDstRd ? rdD : rtD;
        deD.rd1  = rd1D;
        deD.rd2  = rd2D;
        deD.imm  = immD;
    end

    stageReg #(.payloadT(decExT)) i_deReg (
        .clk_i   (clk_i),
        .rstN_i  (rstN_i),
        .en_i    (1'b1),
        .flush_i (stall),  // load-use bubble
        .d_i     (deD),
        .q_o     (deQ)
    );

    // execute
    hazardUnit i_hazardUnit (
        .rsD_i       (rsD),
        .rtD_i       (rtD),
        .rsE_i       (deQ.rs),
        .rtE_i       (deQ.rt),
        .destE_i     (deQ.dest),
        .destM_i     (emQ.dest),
        .destW_i     (mwQ.dest),
        .regWriteM_i (emQ.ctrl.regWrite),
        .regWriteW_i (mwQ.regWrite),
        .memReadE_i  (deQ.ctrl.memRead),
        .fwdA_o      (fwdA),
        .fwdB_o      (fwdB),
        .stall_o     (stall)
    );

    assign srcAE = pickFwd(fwdA, deQ.rd1, emQ.aluRes, wbData);
    assign fwdBE = pickFwd(fwdB, deQ.rd2, emQ.aluRes, wbData);
    assign srcBE = deQ.ctrl.aluSrcImm ? deQ.imm : fwdBE;

    alu i_alu (
        .op_i (deQ.ctrl.aluOp),
        .a_i  (srcAE),
        .b_i  (srcBE),
        .y_o  (aluOutE)
    );

    always_comb begin
        emD.pc        = deQ.pc;
        emD.ctrl      = deQ.ctrl;
        emD.dest      = deQ.dest;
        emD.aluRes    = aluOutE;
        emD.storeData = fwdBE;  // sw data is rt after forwarding
    end

    stageReg #(.payloadT(exMemT)) i_emReg (
        .clk_i   (clk_i),
        .rstN_i  (rstN_i),
        .en_i    (1'b1),
        .flush_i (1'b0),
        .d_i     (emD),
        .q_o     (emQ)
    );

    // memory
    assign memAddr_o  = emQ.aluRes;
    assign memWdata_o = emQ.storeData;
    assign memWe_o    = emQ.ctrl.memWrite;
    assign memRe_o    = emQ.ctrl.memRead;

    always_comb begin
        mwD.pc       = emQ.pc;
        mwD.regWrite = emQ.ctrl.regWrite;
        mwD.memRead  = emQ.ctrl.memRead;
        mwD.dest     = emQ.dest;
        mwD.aluRes   = emQ.aluRes;
    end

    stageReg #(.payloadT(memWbT)) i_mwReg (
        .clk_i   (clk_i),
        .rstN_i  (rstN_i),
        .en_i    (1'b1),
        .flush_i (1'b0),
        .d_i     (mwD),
        .q_o     (mwQ)
    );

    // writeback, load data arrives this cycle
    assign wbData = mwQ.memRead ? memRdata_i : mwQ.aluRes;
    assign wbWe   = mwQ.regWrite && (mwQ.dest != 5'd0);

    assign wbEn_o   = wbWe;
    assign wbReg_o  = mwQ.dest;
    assign wbData_o = wbData;
    assign wbPc_o   = mwQ.pc;

endmodule

/* hdl/stageReg.sv */
module stageReg #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk_i,
    input  logic    rstN_i,
    input  logic    en_i,
    input  logic    flush_i,
    input  payloadT d_i,
    output payloadT q_o
);

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;  // bubble
        end else if (en_i) begin
            q_o <= d_i;
        end
    end

endmodule

/* hdl/hazardUnit.sv */
module hazardUnit (
    input  mipsPkg::regAddrT rsD_i,
    input  mipsPkg::regAddrT rtD_i,
    input  mipsPkg::regAddrT rsE_i,
    input  mipsPkg::regAddrT rtE_i,
    input  mipsPkg::regAddrT destE_i,
    input  mipsPkg::regAddrT destM_i,
    input  mipsPkg::regAddrT destW_i,
    input  logic             regWriteM_i,
    input  logic             regWriteW_i,
    input  logic             memReadE_i,
    output mipsPkg::fwdSelT  fwdA_o,
    output mipsPkg::fwdSelT  fwdB_o,
    output logic             stall_o
);
    import mipsPkg::*;

    logic liveM;
    logic liveW;

    // a write to r0 is never a source
    assign liveM = regWriteM_i && (destM_i != 5'd0);
    assign liveW = regWriteW_i && (destW_i != 5'd0);

    always_comb begin
        fwdA_o = FWD_RF;
        if (liveM && destM_i == rsE_i) begin
            fwdA_o = FWD_MEM;  // youngest result wins
        end else if (liveW && destW_i == rsE_i) begin
            fwdA_o = FWD_WB;
        end

        fwdB_o = FWD_RF;
        if (liveM && destM_i == rtE_i) begin
            fwdB_o = FWD_MEM;
        end else if (liveW && destW_i == rtE_i) begin
            fwdB_o = FWD_WB;
        end
    end

    // checks rt even for i-type, costs a spare bubble at worst
    assign stall_o = memReadE_i && (destE_i != 5'd0)
                     && (destE_i == rsD_i || destE_i == rtD_i);

endmodule

/* hdl/alu.sv */
module alu (
    input  mipsPkg::aluOpT op_i,
    input  mipsPkg::wordT  a_i,
    input  mipsPkg::wordT  b_i,
    output mipsPkg::wordT  y_o
);
    import mipsPkg::*;

    logic lessSigned;

    assign lessSigned = ($signed(a_i) < $signed(b_i));

    always_comb begin
        case (op_i)
            ALU_ADD: y_o = a_i + b_i;  // wraps, no overflow trap
            ALU_SUB: y_o = a_i - b_i;
            ALU_AND: y_o = a_i & b_i;
            ALU_OR:  y_o = a_i | b_i;
            ALU_XOR: y_o = a_i ^ b_i;
            ALU_SLT: y_o = {31'd0, lessSigned};
            ALU_LUI: y_o = {b_i[15:0], 16'h0000};
            default: y_o = '0;
        endcase
    end

endmodule

/* hdl/regFile.sv */
module regFile (
    input  logic             clk_i,
    input  logic             rstN_i,
    input  mipsPkg::regAddrT raddrA_i,
    input  mipsPkg::regAddrT raddrB_i,
    input  logic             we_i,
    input  mipsPkg::regAddrT waddr_i,
    input  mipsPkg::wordT    wdata_i,
    output mipsPkg::wordT    rdataA_o,
    output mipsPkg::wordT    rdataB_o
);
    import mipsPkg::*;

    wordT regs [32];
    logic wrLive;

    assign wrLive = we_i && (waddr_i != 5'd0);  // r0 never written

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle write shows up on the read side
    assign rdataA_o = (wrLive && waddr_i == raddrA_i) ? wdata_i : regs[raddrA_i];
    assign rdataB_o = (wrLive && waddr_i == raddrB_i) ? wdata_i : regs[raddrB_i];

endmodule

/* hdl/decoder.sv */
module decoder (
    input  mipsPkg::wordT instr_i,
    output mipsPkg::ctrlT ctrl_o,
    output mipsPkg::wordT imm_o
);
    import mipsPkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;
    logic        rdIsZero;

    assign opcode   = instr_i[31:26];
    assign funct    = instr_i[5:0];
    assign imm16    = instr_i[15:0];
    assign rdIsZero = (instr_i[15:11] == 5'd0);

    always_comb begin
        ctrl_o = '0;
        imm_o  = {{16{imm16[15]}}, imm16};
        case (opcode)
            OP_RTYPE: begin
                // r-type into r0 is dropped entirely
                if (!rdIsZero) begin
                    ctrl_o.regWrite = 1'b1;
                    ctrl_o.regDstRd = 1'b1;
                    case (funct)
                        FN_ADDU: ctrl_o.aluOp = ALU_ADD;
                        FN_SUBU: ctrl_o.aluOp = ALU_SUB;
                        FN_AND:  ctrl_o.aluOp = ALU_AND;
                        FN_OR:   ctrl_o.aluOp = ALU_OR;
                        FN_XOR:  ctrl_o.aluOp = ALU_XOR;
                        FN_SLT:  ctrl_o.aluOp = ALU_SLT;
                        default: ctrl_o = '0;
                    endcase
                end
            end
            OP_ADDIU: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.aluOp     = ALU_ADD;
            end
            OP_ANDI, OP_ORI: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.aluOp     = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
                imm_o            = {16'h0000, imm16};  // logical ops zero-extend
            end
            OP_LUI: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.aluOp     = ALU_LUI;
                imm_o            = {16'h0000, imm16};
            end
            OP_LW: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.memRead   = 1'b1;
            end
            OP_SW: begin
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.memWrite  = 1'b1;
            end
            default: ctrl_o = '0;
        endcase
    end

endmodule

/* hdl/mipsPkg.sv */
package mipsPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;

    // primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // funct field, r-type only
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,  // zero payload lands here
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,
        ALU_LUI = 3'd6
    } aluOpT;

    typedef enum logic [1:0] {
        FWD_RF  = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwdSelT;

    // all zero means no-op
    typedef struct packed {
        logic  regWrite;
        logic  regDstRd;
        logic  aluSrcImm;
        aluOpT aluOp;
        logic  memRead;
        logic  memWrite;
    } ctrlT;

    typedef struct packed {
        wordT pc;
        wordT instr;
    } fetchDecT;

    typedef struct packed {
        wordT    pc;
        ctrlT    ctrl;
        regAddrT rs;
        regAddrT rt;
        regAddrT dest;
        wordT    rd1;
        wordT    rd2;
        wordT    imm;
    } decExT;

    typedef struct packed {
        wordT    pc;
        ctrlT    ctrl;
        regAddrT dest;
        wordT    aluRes;
        wordT    storeData;
    } exMemT;

    typedef struct packed {
        wordT    pc;
        logic    regWrite;
        logic    memRead;
        regAddrT dest;
        wordT    aluRes;
    } memWbT;

endpackage
